// File: filelist.f
src/mem_stream_pkg.sv
src/stream_fifo.sv
src/mem_to_stream.sv
src/sram_model.sv
src/mem_stream_top.sv
tb/tb_mem_stream_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory stream testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_mem_stream_top \
  -f filelist.f \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "\*\*\* TEST FAILED \*\*\*" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

// File: tb/tb_mem_stream_top.sv
////////////////////////////////////////
// Table-driven testbench for mem_stream_top
// Inputs change on the falling edge and outputs are sampled 1 ns before the rising edge
// Unwritten words are unknown, so their old contents are not compared
// Data of out-of-range responses is not compared, only the err flag
////////////////////////////////////////
`timescale 1ns/100ps

module tb_mem_stream_top;

  localparam int MemWords    = int'(mem_stream_pkg::DefMemWords);
  localparam int Latency     = int'(mem_stream_pkg::DefLatency);
  localparam int NumEntries  = 41;
  localparam int HoldCycles  = 6;
  localparam int TimeoutNs   = NumEntries * (Latency + 20) * 20;
  localparam logic [31:0] Seed = 32'hda6a_2f86;

  // One table row, stall and ready classes pick the back-pressure pattern
  typedef struct packed {
    logic                  we;
    mem_stream_pkg::addr_t addr;
    mem_stream_pkg::data_t wdata;
    logic [1:0]            stall_cls;
    logic [1:0]            rdy_cls;
  } entry_t;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  mem_stream_pkg::addr_t req_addr_i;
  logic                  req_we_i;
  mem_stream_pkg::data_t req_wdata_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  mem_stream_pkg::data_t resp_rdata_o;
  logic                  resp_err_o;
  logic                  resp_valid_o;
  logic                  resp_ready_i;
  logic                  mem_stall_i;

  entry_t                tbl [NumEntries];
  int                    fill_idx;
  logic [1:0]            stall_cls;
  logic [1:0]            rdy_cls;
  // Reference memory and a flag per word that says its contents are known
  mem_stream_pkg::data_t ref_mem [MemWords];
  bit                    ref_known [MemWords];
  mem_stream_pkg::data_t exp_data_q [$];
  logic                  exp_err_q [$];
  bit                    exp_chk_q [$];
  int                    outstanding;
  int                    resp_count;
  int                    hold_cnt;

  always #10 clk_i = ~clk_i;

  mem_stream_top #(
    .MemWords (MemWords),
    .Latency  (Latency)
  ) uut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_addr_i   (req_addr_i),
    .req_we_i     (req_we_i),
    .req_wdata_i  (req_wdata_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_rdata_o (resp_rdata_o),
    .resp_err_o   (resp_err_o),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .mem_stall_i  (mem_stall_i)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_data(input mem_stream_pkg::data_t got, input mem_stream_pkg::data_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED resp_rdata_o: got %h, expected %h", got, exp));
    end
  endtask

  task automatic check_err(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED resp_err_o: got %h, expected %h", got, exp));
    end
  endtask

  task automatic check_ready(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED req_ready_o: got %h, expected %h", got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_error($sformatf("FAILED resp_valid_o: got %h, expected %h", got, exp));
    end
  endtask

  task automatic check_count(input int got, input int exp);
    if (got != exp) begin
      stop_with_error($sformatf("FAILED response count: got %h, expected %h", got, exp));
    end
  endtask

  task automatic add_entry(input logic we, input mem_stream_pkg::addr_t addr,
                           input mem_stream_pkg::data_t wdata,
                           input logic [1:0] sc, input logic [1:0] rc);
    tbl[fill_idx] = '{we: we, addr: addr, wdata: wdata, stall_cls: sc, rdy_cls: rc};
    fill_idx++;
  endtask

  // Stall class 0 none, 1 about a quarter, 2 about half
  // Ready class 0 always, 1 random, 2 held low until the port has been blocked a while
  task automatic build_table();
    fill_idx = 0;
    // Write then read back, and a second write returns the first data
    add_entry(1'b1, 10'h010, 32'hA5A5_0001, 2'd0, 2'd0);
    add_entry(1'b0, 10'h010, 32'h0, 2'd0, 2'd0);
    add_entry(1'b1, 10'h010, 32'h1234_5678, 2'd0, 2'd0);
    add_entry(1'b0, 10'h010, 32'h0, 2'd0, 2'd0);
    // Back-to-back stream without back-pressure
    for (int k = 0; k < 4; k++) begin
      add_entry(1'b1, mem_stream_pkg::addr_t'(32 + k), 32'hB000_0000 + 32'(k), 2'd0, 2'd0);
    end
    for (int k = 0; k < 4; k++) begin
      add_entry(1'b0, mem_stream_pkg::addr_t'(32 + k), 32'h0, 2'd0, 2'd0);
    end
    // Out-of-range writes must leave the last in-range word alone
    add_entry(1'b1, 10'h2FF, 32'hCAFE_0001, 2'd0, 2'd0);
    add_entry(1'b1, 10'h300, 32'hDEAD_BEEF, 2'd0, 2'd0);
    add_entry(1'b1, 10'h3FF, 32'hDEAD_0002, 2'd0, 2'd0);
    add_entry(1'b0, 10'h300, 32'h0, 2'd0, 2'd0);
    add_entry(1'b0, 10'h2FF, 32'h0, 2'd0, 2'd0);
    // Responses held back until req_ready_o has dropped
    for (int k = 0; k < 4; k++) begin
      add_entry(1'b1, mem_stream_pkg::addr_t'(48 + k), 32'hC000_0000 + 32'(k), 2'd0, 2'd2);
    end
    for (int k = 0; k < 4; k++) begin
      add_entry(1'b0, mem_stream_pkg::addr_t'(48 + k), 32'h0, 2'd0, 2'd0);
    end
    // Random stall and ready over write/read pairs
    for (int k = 0; k < 8; k++) begin
      add_entry(1'b1, mem_stream_pkg::addr_t'(64 + k), 32'h5A5A_0000 + 32'(k), 2'd2, 2'd1);
      add_entry(1'b0, mem_stream_pkg::addr_t'(64 + k), 32'h0, 2'd1, 2'd1);
    end
    if (fill_idx != NumEntries) begin
      stop_with_error("Stimulus table length does not match NumEntries");
    end
  endtask

  // Expected response of the request that is accepted at the coming edge
  task automatic predict_response();
    int a;
    a = int'(req_addr_i);
    if (a >= MemWords) begin
      exp_data_q.push_back('0);
      exp_err_q.push_back(1'b1);
      exp_chk_q.push_back(1'b0);
    end else begin
      // Old word goes out, then the write lands
      exp_data_q.push_back(ref_mem[a]);
      exp_err_q.push_back(1'b0);
      exp_chk_q.push_back(ref_known[a]);
      if (req_we_i) begin
        ref_mem[a]   = req_wdata_i;
        ref_known[a] = 1'b1;
      end
    end
  endtask

  task automatic check_response();
    mem_stream_pkg::data_t d;
    logic                  e;
    bit                    c;
    if (exp_data_q.size() == 0) begin
      stop_with_error("Response arrived while no request was outstanding");
    end else begin
      d = exp_data_q.pop_front();
      e = exp_err_q.pop_front();
      c = exp_chk_q.pop_front();
      check_err(resp_err_o, e);
      if (c) begin
        check_data(resp_rdata_o, d);
      end
      resp_count++;
    end
  endtask

  // Back-pressure patterns, driven on the falling edge
  initial begin : backpressure
    logic [31:0] rng;
    rng          = Seed;
    mem_stall_i  = 1'b0;
    resp_ready_i = 1'b0;
    forever begin
      @(negedge clk_i);
      rng = xorshift32(rng);
      case (stall_cls)
        2'd1:    mem_stall_i = (rng[3:0] < 4'd4);
        2'd2:    mem_stall_i = rng[4];
        default: mem_stall_i = 1'b0;
      endcase
      case (rdy_cls)
        2'd1:    resp_ready_i = rng[9];
        2'd2:    resp_ready_i = (hold_cnt >= HoldCycles);
        default: resp_ready_i = 1'b1;
      endcase
    end
  end

  // Samples both handshakes just before each rising edge
  initial begin : monitor
    logic req_fire;
    logic resp_fire;
    logic exp_ready;
    outstanding = 0;
    resp_count  = 0;
    hold_cnt    = 0;
    forever begin
      @(negedge clk_i);
      #9;
      if (rst_ni) begin
        req_fire  = req_valid_i & req_ready_o;
        resp_fire = resp_valid_o & resp_ready_i;
        // Nothing outstanding means no response can be offered
        if (outstanding == 0) begin
          check_valid(resp_valid_o, 1'b0);
        end
        // Ready needs a grant and a free slot, a leaving response frees one
        exp_ready = ~mem_stall_i & ((outstanding < Latency) | resp_fire);
        check_ready(req_ready_o, exp_ready);
        if (req_valid_i && !req_ready_o && outstanding >= Latency) begin
          hold_cnt++;
        end
        if (resp_fire) begin
          check_response();
        end
        if (req_fire) begin
          predict_response();
        end
        outstanding = outstanding + int'(req_fire) - int'(resp_fire);
      end
    end
  end

  initial begin : watchdog
    #(TimeoutNs);
    stop_with_error("Timeout, the table did not finish in time");
  end

  initial begin : driver
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_we_i    = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    build_table();
    stall_cls = tbl[0].stall_cls;
    rdy_cls   = tbl[0].rdy_cls;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    for (int i = 0; i < NumEntries; i++) begin
      @(negedge clk_i);
      req_valid_i = 1'b1;
      req_we_i    = tbl[i].we;
      req_addr_i  = tbl[i].addr;
      req_wdata_i = tbl[i].wdata;
      #9;
      while (!req_ready_o) begin
        @(negedge clk_i);
        #9;
      end
      // Accepted at the coming edge, so the next row's pattern starts now
      if (i + 1 < NumEntries) begin
        stall_cls = tbl[i+1].stall_cls;
        rdy_cls   = tbl[i+1].rdy_cls;
      end else begin
        stall_cls = 2'd0;
        rdy_cls   = 2'd0;
      end
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (outstanding != 0) begin
      @(negedge clk_i);
    end
    // A few idle cycles to catch stray responses
    repeat (5) @(negedge clk_i);
    check_count(resp_count, NumEntries);
    if (hold_cnt == 0) begin
      stop_with_error("req_ready_o never dropped while responses were held back");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: src/mem_stream_top.sv
////////////////////////////////////////
// Memory-to-stream port, adapter plus SRAM model
// Buffer depth equals the SRAM latency for full throughput
// mem_stall_i holds off memory grants
////////////////////////////////////////
`timescale 1ns/100ps

module mem_stream_top #(
  parameter int unsigned MemWords = mem_stream_pkg::DefMemWords,
  parameter int unsigned Latency  = mem_stream_pkg::DefLatency
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Host request stream
  input  mem_stream_pkg::addr_t req_addr_i,
  input  logic                  req_we_i,
  input  mem_stream_pkg::data_t req_wdata_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Host response stream
  output mem_stream_pkg::data_t resp_rdata_o,
  output logic                  resp_err_o,
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  // Grant back-pressure on the memory side
  input  logic                  mem_stall_i
);

  // One buffer slot per cycle of latency
  localparam int unsigned BufDepth = Latency;

  mem_stream_pkg::addr_t mem_addr;
  mem_stream_pkg::data_t mem_wdata;
  mem_stream_pkg::resp_t mem_rresp;
  mem_stream_pkg::resp_t resp;
  logic                  mem_we;
  logic                  mem_valid;
  logic                  mem_gnt;
  logic                  mem_rvalid;

  mem_to_stream #(
    .BufDepth (BufDepth)
  ) u_adapter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_addr_i   (req_addr_i),
    .req_we_i     (req_we_i),
    .req_wdata_i  (req_wdata_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_o       (resp),
    .resp_valid_o (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .mem_addr_o   (mem_addr),
    .mem_we_o     (mem_we),
    .mem_wdata_o  (mem_wdata),
    .mem_valid_o  (mem_valid),
    .mem_gnt_i    (mem_gnt),
    .mem_rresp_i  (mem_rresp),
    .mem_rvalid_i (mem_rvalid)
  );

  sram_model #(
    .MemWords (MemWords),
    .Latency  (Latency)
  ) u_sram (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .stall_i  (mem_stall_i),
    .addr_i   (mem_addr),
    .we_i     (mem_we),
    .wdata_i  (mem_wdata),
    .valid_i  (mem_valid),
    .gnt_o    (mem_gnt),
    .rresp_o  (mem_rresp),
    .rvalid_o (mem_rvalid)
  );

  // Split the response word onto the host ports
  assign resp_rdata_o = resp.rdata;
  assign resp_err_o   = resp.err;

endmodule

// File: src/sram_model.sv
////////////////////////////////////////
// Word-addressed SRAM model with req/gnt requests
// Response comes exactly Latency edges after the grant, no flow control
// Returns the old word, err for addresses at or above MemWords
// Contents are undefined until written
////////////////////////////////////////
`timescale 1ns/100ps

module sram_model #(
  parameter int unsigned MemWords = mem_stream_pkg::DefMemWords,
  parameter int unsigned Latency  = mem_stream_pkg::DefLatency
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  stall_i,
  // Request channel
  input  mem_stream_pkg::addr_t addr_i,
  input  logic                  we_i,
  input  mem_stream_pkg::data_t wdata_i,
  input  logic                  valid_i,
  output logic                  gnt_o,
  // Response channel
  output mem_stream_pkg::resp_t rresp_o,
  output logic                  rvalid_o
);

  mem_stream_pkg::data_t mem_q [MemWords];
  mem_stream_pkg::resp_t rd_resp;
  mem_stream_pkg::resp_t pipe_resp_q [Latency];
  logic [Latency-1:0]    pipe_valid_q;
  logic                  fire;
  logic                  in_range;

  // Stall blocks the grant
  assign gnt_o    = ~stall_i;
  assign fire     = valid_i & gnt_o;
  assign in_range = (addr_i < MemWords);

  // Old contents, read before the write lands
  always_comb begin
    rd_resp.rdata = in_range ? mem_q[addr_i] : '0;
    rd_resp.err   = ~in_range;
  end

  // Out-of-range writes are dropped
  always_ff @(posedge clk_i) begin
    if (fire && we_i && in_range) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Valid tags of the response pipeline
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pipe_valid_q <= '0;
    end else begin
      pipe_valid_q[0] <= fire;
      for (int i = 1; i < Latency; i++) begin
        pipe_valid_q[i] <= pipe_valid_q[i-1];
      end
    end
  end

  // Payload follows its tag one stage per edge
  always_ff @(posedge clk_i) begin
    pipe_resp_q[0] <= rd_resp;
    for (int i = 1; i < Latency; i++) begin
      pipe_resp_q[i] <= pipe_resp_q[i-1];
    end
  end

  assign rresp_o  = pipe_resp_q[Latency-1];
  assign rvalid_o = pipe_valid_q[Latency-1];

  // Response valid must be known once out of reset
  a_rvalid_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(rvalid_o))
    else $error("rvalid_o is unknown");

endmodule

// File: src/mem_to_stream.sv
////////////////////////////////////////
// Adapter from a req/gnt memory without response flow control
// to a valid/ready response stream
// BufDepth bounds outstanding requests and must be 1 or more
// Memory latency must be at least one cycle
////////////////////////////////////////
`timescale 1ns/100ps

module mem_to_stream #(
  parameter int unsigned BufDepth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Host request stream
  input  mem_stream_pkg::addr_t req_addr_i,
  input  logic                  req_we_i,
  input  mem_stream_pkg::data_t req_wdata_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  // Host response stream
  output mem_stream_pkg::resp_t resp_o,
  output logic                  resp_valid_o,
  input  logic                  resp_ready_i,
  // Memory request channel
  output mem_stream_pkg::addr_t mem_addr_o,
  output logic                  mem_we_o,
  output mem_stream_pkg::data_t mem_wdata_o,
  output logic                  mem_valid_o,
  input  logic                  mem_gnt_i,
  // Memory response channel, no ready
  input  mem_stream_pkg::resp_t mem_rresp_i,
  input  logic                  mem_rvalid_i
);

  // Spare top bit makes a wrap visible to the checks
  localparam int unsigned CntWidth = $clog2(BufDepth + 1) + 1;

  typedef logic [CntWidth-1:0] cnt_t;

  cnt_t cnt_q;
  cnt_t cnt_d;
  logic req_fire;
  logic resp_fire;
  logic room;
  logic buf_ready;

  assign req_fire  = req_valid_i & req_ready_o;
  assign resp_fire = resp_valid_o & resp_ready_i;

  // Space for one more response, counting one that leaves this cycle
  assign room = (cnt_q < cnt_t'(BufDepth)) | resp_fire;

  // Both handshakes gated by buffer room
  assign req_ready_o = mem_gnt_i & room;
  assign mem_valid_o = req_valid_i & room;

  // Request fields pass straight through
  assign mem_addr_o  = req_addr_i;
  assign mem_we_o    = req_we_i;
  assign mem_wdata_o = req_wdata_i;

  // Outstanding count, in flight plus buffered
  always_comb begin
    cnt_d = cnt_q;
    if (req_fire && !resp_fire) begin
      cnt_d = cnt_q + cnt_t'(1);
    end else if (resp_fire && !req_fire) begin
      cnt_d = cnt_q - cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Response buffer
  stream_fifo #(
    .Depth (BufDepth)
  ) u_resp_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .data_i  (mem_rresp_i),
    .valid_i (mem_rvalid_i),
    .ready_o (buf_ready),
    .data_o  (resp_o),
    .valid_o (resp_valid_o),
    .ready_i (resp_ready_i)
  );

  // Memory response must always find a free slot
  a_resp_not_lost: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> buf_ready)
    else $error("Memory response hit a full buffer");

  a_cnt_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q == '0) |=> (cnt_q != '1))
    else $error("Outstanding counter underflow");

  a_cnt_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cnt_q == cnt_t'(BufDepth)) |=> (cnt_q <= cnt_t'(BufDepth)))
    else $error("Outstanding counter overflow");

endmodule

// File: src/stream_fifo.sv
////////////////////////////////////////
// Fall-through valid/ready FIFO for response words
// An item entering an empty FIFO is visible on the output in the same cycle
// ready_o stays low while full, even in a cycle with a pop
// Depth must be 1 or more
////////////////////////////////////////
`timescale 1ns/100ps

module stream_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_stream_pkg::resp_t data_i,
  input  logic                  valid_i,
  output logic                  ready_o,
  output mem_stream_pkg::resp_t data_o,
  output logic                  valid_o,
  input  logic                  ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  mem_stream_pkg::resp_t mem_q [Depth];
  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t cnt_q;
  cnt_t cnt_d;
  logic empty;
  logic full;
  logic push;
  logic pop;

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == cnt_t'(Depth));

  // Output side, bypass the storage while empty
  assign valid_o = ~empty | valid_i;
  assign data_o  = empty ? data_i : mem_q[rd_ptr_q];
  assign ready_o = ~full;

  // Item consumed straight from the input is never stored
  assign push = valid_i & ready_o & ~(empty & ready_i);
  // Pop only touches stored items
  assign pop  = ~empty & ready_i;

  // Occupancy update
  always_comb begin
    cnt_d = cnt_q;
    if (push && !pop) begin
      cnt_d = cnt_q + cnt_t'(1);
    end else if (pop && !push) begin
      cnt_d = cnt_q - cnt_t'(1);
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (push) begin
        // Wrap at the last slot
        wr_ptr_q <= (wr_ptr_q == ptr_t'(Depth - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(Depth - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // A push must land on a free slot, never on the oldest stored item
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> (empty || (wr_ptr_q != rd_ptr_q)))
    else $error("Push into full FIFO");

  // A pop must take a stored item, never a free slot
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop |-> (full || (wr_ptr_q != rd_ptr_q)))
    else $error("Pop from empty FIFO");

endmodule

// File: src/mem_stream_pkg.sv
////////////////////////////////////////
// Shared widths, types and defaults of the memory stream port
// Addresses are word addresses and there are no byte enables
// DefMemWords stays below 2**AddrWidth so the error path is reachable
////////////////////////////////////////
package mem_stream_pkg;

  // Word address width
  localparam int unsigned AddrWidth = 10;
  // Data word width
  localparam int unsigned DataWidth = 32;

  // Default memory size in words
  localparam int unsigned DefMemWords = 768;
  // Default SRAM response latency in cycles
  localparam int unsigned DefLatency = 2;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;

  // Response word with the old contents and the range error flag
  typedef struct packed {
    data_t rdata;
    logic  err;
  } resp_t;

endpackage
